//--- compile.f
hdl/tx_pkg.sv
hdl/tx_buff.sv
hdl/tx_desc_if.sv
hdl/tx_frame_ingest.sv
hdl/tx_frame_drain.sv
hdl/tx_stats.sv
hdl/tx_path_top.sv
sim/tx_path_sva.sv
sim/tb_tx_path.sv

//--- hdl/tx_buff.sv
`timescale 1ns/1ps

// simple dual-port ram, one clock
// write side: address and data are flopped, then written on the next edge
// read side: one cycle from rd_addr to rd_data
module tx_buff #(
    parameter type payload_t = logic [63:0],
    parameter int  AW        = 8
) (
    input  logic          clk,
    input  logic [AW-1:0] wr_addr,
    input  payload_t      wr_data,
    input  logic [AW-1:0] rd_addr,
    output payload_t      rd_data
);

    payload_t      mem [2**AW];  // storage array
    logic [AW-1:0] wr_addr_q;    // write stage
    payload_t      wr_data_q;

    ////////////////////
    // write port
    ////////////////////
    // no enable, the writer parks on its last written slot when idle
    always_ff @(posedge clk) begin
        wr_addr_q      <= wr_addr;
        wr_data_q      <= wr_data;
        mem[wr_addr_q] <= wr_data_q;  // lands 2 edges after presentation
    end

    ////////////////////
    // read port
    ////////////////////
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];  // old data on same-edge collision
    end

endmodule

//--- hdl/tx_desc_if.sv
`timescale 1ns/1ps

// ring pointers and buffer release between ingest and drain
interface tx_desc_if #(
    parameter int AW  = 8,
    parameter int DAW = 3
);

    logic [DAW:0]  commit_ptr;      // committed descriptors, mod 2*depth
    logic [DAW:0]  done_ptr;        // finished descriptors, mod 2*depth
    logic [AW-1:0] release_addr;    // first word after the last finished frame
    logic          release_strobe;  // release_addr just moved

    // ingest side owns the commit pointer
    modport ingest (
        output commit_ptr,
        input  done_ptr,
        input  release_addr,
        input  release_strobe
    );

    // drain side owns everything about consumption
    modport drain (
        input  commit_ptr,
        output done_ptr,
        output release_addr,
        output release_strobe
    );

endinterface

//--- hdl/tx_frame_drain.sv
`timescale 1ns/1ps

module tx_frame_drain
    import tx_pkg::*;
#(
    parameter int AW        = 8,
    parameter int DAW       = 3,
    parameter int IFG_WORDS = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pause,
    output logic [DAW-1:0]    desc_rd_addr,
    input  tx_desc_t          desc_rd_data,
    output logic [AW-1:0]     buf_rd_addr,
    input  tx_beat_t          buf_rd_data,
    output logic              out_valid,
    output logic              out_start,
    output logic              out_last,
    output tx_word_t          out_data,
    output tx_keep_t          out_keep,
    output logic              frame_done,
    output logic [BCNT_W-1:0] done_bytes,
    tx_desc_if.drain          desc
);

    localparam int GW = $clog2(IFG_WORDS + 2);  // gap counter width

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_STREAM
    } state_t;

    state_t            state;
    logic [GW-1:0]     gap_cnt;      // idle cycles still owed
    logic [AW-1:0]     rd_ptr;       // next word to read
    logic [WCNT_W-1:0] words_left;
    logic [BCNT_W-1:0] frame_bytes;  // held for frame_done
    logic              first;        // next issue is word 0

    logic              pending;
    logic              issue;
    logic              issue_last;

    assign pending    = desc.commit_ptr != desc.done_ptr;
    assign issue      = state == ST_STREAM;
    assign issue_last = issue && (words_left == WCNT_W'(1));

    // oldest unfinished descriptor is always on the read port
    assign desc_rd_addr = desc.done_ptr[DAW-1:0];
    assign buf_rd_addr  = rd_ptr;

    // ram output lines up with the delayed issue flags
    assign out_data = buf_rd_data.data;
    assign out_keep = buf_rd_data.keep;

    ////////////////////
    // fsm
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state               <= ST_IDLE;
            gap_cnt             <= '0;
            rd_ptr              <= '0;
            words_left          <= '0;
            first               <= 1'b0;
            out_valid           <= 1'b0;
            out_start           <= 1'b0;
            out_last            <= 1'b0;
            frame_done          <= 1'b0;
            done_bytes          <= '0;
            desc.done_ptr       <= '0;
            desc.release_addr   <= '0;
            desc.release_strobe <= 1'b0;
        end else begin
            out_valid           <= issue;  // read data valid one cycle later
            out_start           <= issue && first;
            out_last            <= issue_last;
            frame_done          <= 1'b0;
            desc.release_strobe <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                    // pause only looked at here, never mid frame
                    if (pending && !pause && (gap_cnt <= GW'(1))) begin
                        state <= ST_FETCH;
                    end
                end

                ST_FETCH: begin
                    rd_ptr      <= desc_rd_data.addr[AW-1:0];
                    words_left  <= desc_rd_data.words;
                    frame_bytes <= desc_rd_data.bytes;
                    first       <= 1'b1;
                    state       <= ST_STREAM;
                end

                ST_STREAM: begin
                    rd_ptr     <= rd_ptr + AW'(1);  // one read per cycle
                    words_left <= words_left - 1'b1;
                    first      <= 1'b0;
                    if (issue_last) begin
                        state               <= ST_IDLE;
                        gap_cnt             <= GW'(IFG_WORDS);
                        desc.done_ptr       <= desc.done_ptr + 1'b1;
                        desc.release_addr   <= rd_ptr + AW'(1);
                        desc.release_strobe <= 1'b1;
                        frame_done          <= 1'b1;
                        done_bytes          <= frame_bytes;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/tx_frame_ingest.sv
`timescale 1ns/1ps

module tx_frame_ingest
    import tx_pkg::*;
#(
    parameter int AW  = 8,
    parameter int DAW = 3
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  tx_word_t         in_data,
    input  tx_keep_t         in_keep,
    input  logic             in_last,
    output logic [AW-1:0]    buf_wr_addr,
    output tx_beat_t         buf_wr_data,
    output logic [DAW-1:0]   desc_wr_addr,
    output tx_desc_t         desc_wr_data,
    output logic             frame_drop,
    tx_desc_if.ingest        desc
);

    localparam logic [DAW:0] RING_DEPTH = (DAW+1)'(2**DAW);

    // popcount of one keep mask
    function automatic logic [BCNT_W-1:0] keep_bytes(input tx_keep_t keep);
        logic [BCNT_W-1:0] n;
        n = '0;
        for (int i = 0; i < WORD_BYTES; i++) begin
            n = n + BCNT_W'(keep[i]);
        end
        return n;
    endfunction

    logic [AW-1:0]     wr_ptr;       // next free word slot
    logic [AW-1:0]     frame_start;  // rewind point for a drop
    logic [AW-1:0]     rel_addr;     // local copy of drain release point
    logic [WCNT_W-1:0] word_cnt;     // words so far in this frame
    logic [BCNT_W-1:0] byte_cnt;     // bytes so far in this frame
    logic              ovf;          // sticky, frame no longer fits
    logic [DAW:0]      wr_desc;      // descriptors written, incl. uncommitted
    logic [2:0]        commit_pipe;  // covers the write pipeline of both rams

    logic              word_fits;
    logic              ring_full;
    logic              word_ok;
    logic [BCNT_W-1:0] word_bytes;

    ////////////////////
    // space checks
    ////////////////////
    // one slot always kept empty so wr_ptr == rel_addr means empty
    assign word_fits  = (wr_ptr + AW'(1)) != rel_addr;
    assign ring_full  = (wr_desc - desc.done_ptr) == RING_DEPTH;  // counts pending commits
    assign word_ok    = in_valid && !ovf && word_fits;
    assign word_bytes = keep_bytes(in_keep);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr          <= '0;
            frame_start     <= '0;
            rel_addr        <= '0;
            word_cnt        <= '0;
            byte_cnt        <= '0;
            ovf             <= 1'b0;
            wr_desc         <= '0;
            commit_pipe     <= '0;
            desc.commit_ptr <= '0;
            frame_drop      <= 1'b0;
            buf_wr_addr     <= '0;
            desc_wr_addr    <= '0;
        end else begin
            frame_drop  <= 1'b0;
            commit_pipe <= {commit_pipe[1:0], 1'b0};
            if (commit_pipe[2]) begin
                desc.commit_ptr <= desc.commit_ptr + 1'b1;  // now visible to drain
            end
            if (desc.release_strobe) begin
                rel_addr <= desc.release_addr;
            end

            // accepted word goes out to the buffer
            if (word_ok) begin
                buf_wr_addr <= wr_ptr;
                wr_ptr      <= wr_ptr + AW'(1);
            end

            if (in_valid) begin
                if (in_last) begin
                    if (word_ok && !ring_full) begin
                        // clean frame, write its descriptor
                        desc_wr_addr       <= wr_desc[DAW-1:0];
                        desc_wr_data.addr  <= ADDR_W'(frame_start);
                        desc_wr_data.words <= word_cnt + 1'b1;
                        desc_wr_data.bytes <= byte_cnt + word_bytes;
                        wr_desc            <= wr_desc + 1'b1;
                        commit_pipe[0]     <= 1'b1;
                        frame_start        <= wr_ptr + AW'(1);
                    end else begin
                        wr_ptr     <= frame_start;  // discard the whole frame
                        frame_drop <= 1'b1;
                    end
                    ovf      <= 1'b0;
                    word_cnt <= '0;
                    byte_cnt <= '0;
                end else begin
                    if (!word_fits) begin
                        ovf <= 1'b1;  // rest of frame is thrown away
                    end
                    if (word_ok) begin
                        word_cnt <= word_cnt + 1'b1;
                        byte_cnt <= byte_cnt + word_bytes;
                    end
                end
            end
        end
    end

    // payload, follows the address register above
    always_ff @(posedge clk) begin
        if (word_ok) begin
            buf_wr_data.data <= in_data;
            buf_wr_data.keep <= in_keep;
        end
    end

endmodule

//--- hdl/tx_path_top.sv
`timescale 1ns/1ps

module tx_path_top
    import tx_pkg::*;
#(
    parameter int AW        = 8,
    parameter int DAW       = 3,
    parameter int IFG_WORDS = 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  tx_word_t in_data,
    input  tx_keep_t in_keep,
    input  logic     in_last,
    input  logic     pause,
    output logic     out_valid,
    output logic     out_start,
    output logic     out_last,
    output tx_word_t out_data,
    output tx_keep_t out_keep,
    output tx_cnt_t  frames_sent,
    output tx_cnt_t  bytes_sent,
    output tx_cnt_t  frames_dropped
);

    logic [AW-1:0]     buf_wr_addr;
    tx_beat_t          buf_wr_data;
    logic [AW-1:0]     buf_rd_addr;
    tx_beat_t          buf_rd_data;
    logic [DAW-1:0]    desc_wr_addr;
    tx_desc_t          desc_wr_data;
    logic [DAW-1:0]    desc_rd_addr;
    tx_desc_t          desc_rd_data;
    logic              frame_drop;
    logic              frame_done;
    logic [BCNT_W-1:0] done_bytes;

    tx_desc_if #(.AW(AW), .DAW(DAW)) u_desc_if ();

    ////////////////////
    // storage
    ////////////////////
    tx_buff #(.payload_t(tx_beat_t), .AW(AW)) u_word_buf (
        .clk     (clk),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    tx_buff #(.payload_t(tx_desc_t), .AW(DAW)) u_desc_ring (
        .clk     (clk),
        .wr_addr (desc_wr_addr),
        .wr_data (desc_wr_data),
        .rd_addr (desc_rd_addr),
        .rd_data (desc_rd_data)
    );

    ////////////////////
    // datapath
    ////////////////////
    tx_frame_ingest #(.AW(AW), .DAW(DAW)) u_ingest (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_keep      (in_keep),
        .in_last      (in_last),
        .buf_wr_addr  (buf_wr_addr),
        .buf_wr_data  (buf_wr_data),
        .desc_wr_addr (desc_wr_addr),
        .desc_wr_data (desc_wr_data),
        .frame_drop   (frame_drop),
        .desc         (u_desc_if.ingest)
    );

    tx_frame_drain #(.AW(AW), .DAW(DAW), .IFG_WORDS(IFG_WORDS)) u_drain (
        .clk          (clk),
        .rst_n        (rst_n),
        .pause        (pause),
        .desc_rd_addr (desc_rd_addr),
        .desc_rd_data (desc_rd_data),
        .buf_rd_addr  (buf_rd_addr),
        .buf_rd_data  (buf_rd_data),
        .out_valid    (out_valid),
        .out_start    (out_start),
        .out_last     (out_last),
        .out_data     (out_data),
        .out_keep     (out_keep),
        .frame_done   (frame_done),
        .done_bytes   (done_bytes),
        .desc         (u_desc_if.drain)
    );

    tx_stats u_stats (
        .clk            (clk),
        .rst_n          (rst_n),
        .frame_done     (frame_done),
        .done_bytes     (done_bytes),
        .frame_drop     (frame_drop),
        .frames_sent    (frames_sent),
        .bytes_sent     (bytes_sent),
        .frames_dropped (frames_dropped)
    );

endmodule

//--- hdl/tx_pkg.sv
package tx_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int WORD_BYTES = 8;   // bytes per data word
    localparam int ADDR_W     = 12;  // descriptor address field, top uses low AW bits
    localparam int WCNT_W     = 12;  // words per frame
    localparam int BCNT_W     = 16;  // bytes per frame

    // one 64-bit data word on the stream
    typedef logic [8*WORD_BYTES-1:0] tx_word_t;

    // byte valid mask, low bytes first, all ones except on the last word
    typedef logic [WORD_BYTES-1:0] tx_keep_t;

    // word buffer entry
    typedef struct packed {
        tx_word_t data;
        tx_keep_t keep;
    } tx_beat_t;

    // descriptor ring entry, one per stored frame
    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // first word address
        logic [WCNT_W-1:0] words;  // word count, never zero
        logic [BCNT_W-1:0] bytes;  // sum of keep popcounts
    } tx_desc_t;

    ////////////////////
    // statistics
    ////////////////////
    typedef logic [31:0] tx_cnt_t;

    localparam tx_cnt_t CNT_MAX = '1;  // saturation value

endpackage

//--- hdl/tx_stats.sv
`timescale 1ns/1ps

module tx_stats
    import tx_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              frame_done,
    input  logic [BCNT_W-1:0] done_bytes,
    input  logic              frame_drop,
    output tx_cnt_t           frames_sent,
    output tx_cnt_t           bytes_sent,
    output tx_cnt_t           frames_dropped
);

    logic [32:0] bytes_sum;  // one extra bit to catch the carry

    assign bytes_sum = {1'b0, bytes_sent} + 33'(done_bytes);

    ////////////////////
    // counters
    ////////////////////
    // all saturate at CNT_MAX
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            frames_sent    <= '0;
            bytes_sent     <= '0;
            frames_dropped <= '0;
        end else begin
            if (frame_done) begin
                if (frames_sent != CNT_MAX) begin
                    frames_sent <= frames_sent + 1'b1;
                end
                if (bytes_sum[32]) begin
                    bytes_sent <= CNT_MAX;  // clamp on overflow
                end else begin
                    bytes_sent <= bytes_sum[31:0];
                end
            end
            if (frame_drop && (frames_dropped != CNT_MAX)) begin
                frames_dropped <= frames_dropped + 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_tx_path \
    -f compile.f -o tb_tx_path \
    && ./obj_dir/tb_tx_path | tee sim.log \
    || { echo "build or simulation error"; exit 1; }

grep -qx "all tests passed" sim.log && exit 0 || exit 1

//--- sim/tb_tx_path.sv
`timescale 1ns/1ps

module tb_tx_path;
    import tx_pkg::*;

    localparam int AW         = 6;            // 63 usable words, overflow reachable
    localparam int DAW        = 3;
    localparam int IFG_WORDS  = 2;
    localparam int BUF_WORDS  = 2**AW - 1;    // one slot stays empty
    localparam int RING       = 2**DAW;
    localparam int N_FRAMES   = 10 + 5 + 5 + 10 + 8;
    localparam int MAX_CYCLES = 2 * (N_FRAMES * (12 + 40) + 300 + 16);

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    tx_word_t in_data;
    tx_keep_t in_keep;
    logic     in_last;
    logic     pause;
    logic     out_valid;
    logic     out_start;
    logic     out_last;
    tx_word_t out_data;
    tx_keep_t out_keep;
    tx_cnt_t  frames_sent;
    tx_cnt_t  bytes_sent;
    tx_cnt_t  frames_dropped;

    // reference model state
    tx_beat_t    exp_beat_q[$];
    logic [1:0]  exp_flag_q[$];   // {start, last}
    int          exp_len_q[$];    // words per accepted frame
    int          words_used;      // words held, accepted and not yet out
    int          descs_used;
    tx_cnt_t     exp_frames;
    tx_cnt_t     exp_bytes;
    tx_cnt_t     exp_drops;
    logic [31:0] rng;
    int          n_checks;
    int          data_errs;
    int          frame_errs;
    int          cnt_errs;
    int          cycle_cnt;
    int          idle_run;        // idle output cycles seen
    logic        in_frame;
    logic [1:0]  pause_hist;      // pause at the last two edges

    tx_path_top #(.AW(AW), .DAW(DAW), .IFG_WORDS(IFG_WORDS)) u_tx_path_top (.*);

    bind tx_path_top tx_path_sva u_sva (
        .clk            (clk),
        .rst_n          (rst_n),
        .out_valid      (out_valid),
        .out_start      (out_start),
        .out_last       (out_last),
        .ifg_words      (32'(IFG_WORDS)),
        .frames_sent    (frames_sent),
        .bytes_sent     (bytes_sent),
        .frames_dropped (frames_dropped)
    );

    always #4 clk = ~clk;  // 8 ns

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // whole frame kept only if every word and one descriptor fit
    function automatic bit frame_fits(input int len);
        return (words_used + len <= BUF_WORDS) && (descs_used < RING);
    endfunction

    task automatic check_beat(input tx_beat_t exp, input tx_beat_t got);
        n_checks++;
        if (got !== exp) begin
            data_errs++;
            $display("[FAIL] %0t: word expected %h/%h got %h/%h",
                     $time, exp.data, exp.keep, got.data, got.keep);
        end
    endtask

    task automatic check_flags(input logic [1:0] exp, input logic [1:0] got);
        n_checks++;
        if (got !== exp) begin
            frame_errs++;
            $display("[FAIL] %0t: start/last expected %b got %b", $time, exp, got);
        end
    endtask

    task automatic check_cnt(input tx_cnt_t exp, input tx_cnt_t got, input string what);
        n_checks++;
        if (got !== exp) begin
            cnt_errs++;
            $display("[FAIL] %0t: %s expected %0d got %0d", $time, what, exp, got);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////
    task automatic send_frame(input int len, input int gap);
        tx_beat_t beat;
        int       nbytes;
        bit       ok;
        ok     = frame_fits(len);
        nbytes = 1 + int'(next_rand() % 8);  // valid bytes in last word
        if (ok) begin
            words_used += len;
            descs_used++;
            exp_frames++;
            exp_bytes += tx_cnt_t'((len - 1) * WORD_BYTES + nbytes);
            exp_len_q.push_back(len);
        end else begin
            exp_drops++;
        end
        for (int i = 0; i < len; i++) begin
            beat.data = {next_rand(), next_rand()};
            beat.keep = (i == len - 1) ? tx_keep_t'((1 << nbytes) - 1) : '1;
            @(negedge clk);
            in_valid = 1'b1;
            in_data  = beat.data;
            in_keep  = beat.keep;
            in_last  = (i == len - 1);
            if (ok) begin
                exp_beat_q.push_back(beat);
                exp_flag_q.push_back({i == 0, i == len - 1});
            end
        end
        if (gap > 0) begin
            @(negedge clk);
            in_valid = 1'b0;
            in_last  = 1'b0;
            repeat (gap - 1) @(negedge clk);
        end
    endtask

    task automatic wait_drained();
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;
        while (exp_beat_q.size() != 0) @(negedge clk);
        repeat (6) @(negedge clk);  // release and counters settle
    endtask

    ////////////////////
    // compare
    ////////////////////
    always @(posedge clk) begin
        tx_beat_t   got;
        tx_beat_t   exp_b;
        logic [1:0] exp_f;
        if (rst_n) begin
            got.data = out_data;
            got.keep = out_keep;
            if (out_start && pause_hist[1]) begin
                frame_errs++;
                $display("frame started while pause was high, at %0t", $time);
            end
            if (out_start && idle_run < IFG_WORDS) begin
                frame_errs++;
                $display("[FAIL] %0t: idle gap %0d below %0d", $time, idle_run, IFG_WORDS);
            end
            if (in_frame && !out_valid) begin
                frame_errs++;
                $display("frame was cut short at %0t", $time);
            end
            if (out_valid && exp_beat_q.size() == 0) begin
                frame_errs++;
                $display("output word with nothing expected at %0t", $time);
            end else if (out_valid) begin
                exp_b = exp_beat_q.pop_front();
                exp_f = exp_flag_q.pop_front();
                check_beat(exp_b, got);
                check_flags(exp_f, {out_start, out_last});
                if (exp_f[0]) begin
                    words_used -= exp_len_q.pop_front();  // frame leaves the buffer
                    descs_used--;
                end
            end
            idle_run = out_valid ? 0 : idle_run + 1;
            in_frame = out_valid && !out_last;
        end
        pause_hist = {pause_hist[0], pause};
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        in_keep    = '0;
        in_last    = 1'b0;
        pause      = 1'b0;
        rng        = 32'd96652;
        idle_run   = IFG_WORDS;
        exp_frames = '0;
        exp_bytes  = '0;
        exp_drops  = '0;
        in_frame   = 1'b0;
        pause_hist = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int f = 0; f < 10; f++) begin  // spaced single frames
            send_frame(1 + int'(next_rand() % 12), 1 + int'(next_rand() % 6));
            wait_drained();
        end
        for (int f = 0; f < 5; f++) begin   // back to back, at most 60 words
            send_frame(1 + int'(next_rand() % 12), 0);
        end
        wait_drained();

        // long pause, frames pile up then drain
        @(negedge clk);
        pause = 1'b1;
        for (int f = 0; f < 5; f++) begin
            send_frame(1 + int'(next_rand() % 12), 2);
        end
        repeat (200) @(negedge clk);
        pause = 1'b0;
        wait_drained();

        // ring runs out first, short frames never fill the buffer
        @(negedge clk);
        pause = 1'b1;
        for (int f = 0; f < 10; f++) begin
            send_frame(1 + int'(next_rand() % 4), 1);  // at most 40 words
        end
        repeat (8) @(negedge clk);
        check_cnt(exp_drops, frames_dropped, "frames_dropped");
        pause = 1'b0;
        wait_drained();

        // buffer runs out, 7 long frames at most fit so the ring never fills
        @(negedge clk);
        pause = 1'b1;
        for (int f = 0; f < 8; f++) begin
            send_frame(9 + int'(next_rand() % 4), 1);
        end
        repeat (8) @(negedge clk);
        check_cnt(exp_drops, frames_dropped, "frames_dropped");
        pause = 1'b0;
        wait_drained();

        check_cnt(exp_frames, frames_sent, "frames_sent");
        check_cnt(exp_bytes, bytes_sent, "bytes_sent");
        check_cnt(exp_drops, frames_dropped, "frames_dropped");
        $display("checks %0d, data errors %0d, framing errors %0d, counter errors %0d",
                 n_checks, data_errs, frame_errs, cnt_errs);
        if (data_errs + frame_errs + cnt_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sim/tx_path_sva.sv
`timescale 1ns/1ps

module tx_path_sva
    import tx_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        out_valid,
    input logic        out_start,
    input logic        out_last,
    input logic [31:0] ifg_words,
    input tx_cnt_t     frames_sent,
    input tx_cnt_t     bytes_sent,
    input tx_cnt_t     frames_dropped
);

    logic [7:0] idle_cnt;  // idle cycles since last word, saturating

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idle_cnt <= '1;  // no previous frame
        end else if (out_valid) begin
            idle_cnt <= '0;
        end else if (idle_cnt != '1) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    ////////////////////
    // output framing
    ////////////////////
    a_start_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_start |-> out_valid)
        else $error("out_start seen without out_valid");

    a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> out_valid)
        else $error("out_last seen without out_valid");

    // words of one frame are contiguous
    a_no_hole: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_last) |=> out_valid)
        else $error("out_valid dropped inside a frame");

    a_ifg: assert property (@(posedge clk) disable iff (!rst_n)
        out_start |-> (32'(idle_cnt) >= ifg_words))
        else $error("idle gap before frame start too short");

    // sync reset, outputs cleared one edge after reset is seen
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!out_valid && !out_start && !out_last && frames_sent == '0
                    && bytes_sent == '0 && frames_dropped == '0))
        else $error("outputs not quiet during reset");

endmodule
